// ==== common/axil_pkg.sv ====
// AXI4-Lite bus definitions
package axil_pkg;

    // --------------------------------------------------
    // Bus widths
    // --------------------------------------------------
    localparam int ADDR_W = 16;
    localparam int DATA_W = 32;
    localparam int STRB_W = DATA_W / 8;
    localparam int RESP_W = 2;

    // Only OKAY is ever returned
    localparam logic [RESP_W-1:0] RESP_OKAY = 2'b00;

    // --------------------------------------------------
    // Bus-side payloads
    // --------------------------------------------------
    // W channel beat
    typedef struct packed {
        logic [DATA_W-1:0] data;
        logic [STRB_W-1:0] strb;
    } axil_wdata_t;

    // One committed register write
    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] data;
        logic [STRB_W-1:0] strb;
    } csr_wr_t;

    typedef struct packed {
        logic [ADDR_W-1:0] addr;
    } csr_rd_t;

endpackage

// ==== common/csr_pkg.sv ====
// UART register map
package csr_pkg;

    // --------------------------------------------------
    // Register addresses
    // --------------------------------------------------
    localparam logic [axil_pkg::ADDR_W-1:0] ADDR_STAT    = 16'h0004;
    localparam logic [axil_pkg::ADDR_W-1:0] ADDR_CTRL    = 16'h0008;
    localparam logic [axil_pkg::ADDR_W-1:0] ADDR_LPMODE  = 16'h000C;
    localparam logic [axil_pkg::ADDR_W-1:0] ADDR_INTSTAT = 16'h0010;
    localparam logic [axil_pkg::ADDR_W-1:0] ADDR_ID      = 16'h0FFC;

    // --------------------------------------------------
    // Field positions
    // --------------------------------------------------
    localparam int CTRL_BAUD_LSB  = 0;
    localparam int CTRL_BAUD_W    = 2;
    localparam int CTRL_TXEN_BIT  = 4;
    localparam int CTRL_RXEN_BIT  = 5;
    localparam int CTRL_TXST_BIT  = 6;
    localparam int LPMODE_DIV_LSB = 0;
    localparam int LPMODE_DIV_W   = 8;
    localparam int LPMODE_EN_BIT  = 31;
    localparam int STAT_BUSY_BIT  = 0;
    localparam int STAT_RXE_BIT   = 4;
    localparam int STAT_TXF_BIT   = 5;
    localparam int INT_TX_BIT     = 0;
    localparam int INT_RX_BIT     = 1;

    localparam logic [axil_pkg::DATA_W-1:0] ID_VALUE = 32'hCAFE0666;

    // --------------------------------------------------
    // Hardware-side structs
    // --------------------------------------------------
    typedef struct packed {
        logic [CTRL_BAUD_W-1:0]  baud;
        logic                    txen;
        logic                    rxen;
        logic                    txst;
        logic [LPMODE_DIV_W-1:0] div;
        logic                    lp_en;
    } uart_ctrl_t;

    // Levels, load enables and set pulses from the UART core
    typedef struct packed {
        logic busy_en;
        logic busy;
        logic rxe;
        logic txf;
        logic txen_en;
        logic txen;
        logic rxen_en;
        logic rxen;
        logic tx_set;
        logic rx_set;
    } uart_stat_t;

    localparam uart_ctrl_t CTRL_RESET = '0;

endpackage

// ==== axil/axil_hold.sv ====
// Bus channel capture slot
`timescale 1ns/1ps

module axil_hold #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     in_valid,
    input  payload_t in_data,
    output logic     in_ready,
    input  logic     take,
    output logic     full,
    output payload_t data
);

    logic load;

    // Accept only into an empty slot
    assign in_ready = ~full;
    assign load     = in_valid & in_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            full <= 1'b0;
        end else if (load) begin
            full <= 1'b1;
        end else if (take) begin
            full <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            data <= in_data;
        end
    end

    a_data_held: assert property (@(posedge clk) disable iff (rst)
        full && !take |=> $stable(data));

endmodule

// ==== axil/axil_write_ctrl.sv ====
// AXI4-Lite write channel controller
`timescale 1ns/1ps

module axil_write_ctrl (
    input  logic                          clk,
    input  logic                          rst,
    input  logic [axil_pkg::ADDR_W-1:0]   axil_awaddr,
    input  logic                          axil_awvalid,
    output logic                          axil_awready,
    input  logic [axil_pkg::DATA_W-1:0]   axil_wdata,
    input  logic [axil_pkg::STRB_W-1:0]   axil_wstrb,
    input  logic                          axil_wvalid,
    output logic                          axil_wready,
    output logic [axil_pkg::RESP_W-1:0]   axil_bresp,
    output logic                          axil_bvalid,
    input  logic                          axil_bready,
    output logic                          wr_en,
    output axil_pkg::csr_wr_t             wr_req
);

    logic                        aw_full;
    logic                        w_full;
    logic [axil_pkg::ADDR_W-1:0] aw_addr;
    axil_pkg::axil_wdata_t       w_in;
    axil_pkg::axil_wdata_t       w_beat;

    assign w_in.data = axil_wdata;
    assign w_in.strb = axil_wstrb;

    // --------------------------------------------------
    // AW and W captured independently
    // --------------------------------------------------
    axil_hold #(
        .payload_t (logic [axil_pkg::ADDR_W-1:0])
    ) u_aw_hold (
        .clk      (clk),
        .rst      (rst),
        .in_valid (axil_awvalid),
        .in_data  (axil_awaddr),
        .in_ready (axil_awready),
        .take     (wr_en),
        .full     (aw_full),
        .data     (aw_addr)
    );

    axil_hold #(
        .payload_t (axil_pkg::axil_wdata_t)
    ) u_w_hold (
        .clk      (clk),
        .rst      (rst),
        .in_valid (axil_wvalid),
        .in_data  (w_in),
        .in_ready (axil_wready),
        .take     (wr_en),
        .full     (w_full),
        .data     (w_beat)
    );

    // Commit once both halves are in and the last response is gone
    assign wr_en       = aw_full & w_full & ~axil_bvalid;
    assign wr_req.addr = aw_addr;
    assign wr_req.data = w_beat.data;
    assign wr_req.strb = w_beat.strb;

    always_ff @(posedge clk) begin
        if (rst) begin
            axil_bvalid <= 1'b0;
        end else if (wr_en) begin
            axil_bvalid <= 1'b1;
        end else if (axil_bready) begin
            axil_bvalid <= 1'b0;
        end
    end

    assign axil_bresp = axil_pkg::RESP_OKAY;

    a_bvalid_hold: assert property (@(posedge clk) disable iff (rst)
        axil_bvalid && !axil_bready |=> axil_bvalid);

endmodule

// ==== axil/axil_read_ctrl.sv ====
// AXI4-Lite read channel controller
`timescale 1ns/1ps

module axil_read_ctrl (
    input  logic                          clk,
    input  logic                          rst,
    input  logic [axil_pkg::ADDR_W-1:0]   axil_araddr,
    input  logic                          axil_arvalid,
    output logic                          axil_arready,
    output logic [axil_pkg::DATA_W-1:0]   axil_rdata,
    output logic [axil_pkg::RESP_W-1:0]   axil_rresp,
    output logic                          axil_rvalid,
    input  logic                          axil_rready,
    output logic                          rd_en,
    output axil_pkg::csr_rd_t             rd_req,
    input  logic [axil_pkg::DATA_W-1:0]   rd_data
);

    logic                        ar_full;
    logic [axil_pkg::ADDR_W-1:0] ar_addr;
    logic                        r_done;
    logic                        rd_en_q;
    logic                        rvalid_q;
    logic [axil_pkg::DATA_W-1:0] rdata_q;

    assign r_done = axil_rvalid & axil_rready;

    axil_hold #(
        .payload_t (logic [axil_pkg::ADDR_W-1:0])
    ) u_ar_hold (
        .clk      (clk),
        .rst      (rst),
        .in_valid (axil_arvalid),
        .in_data  (axil_araddr),
        .in_ready (axil_arready),
        .take     (r_done),
        .full     (ar_full),
        .data     (ar_addr)
    );

    // A read stays outstanding for as long as rvalid is up
    assign rd_en       = ar_full & ~axil_rvalid;
    assign rd_req.addr = ar_addr;

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_en_q  <= 1'b0;
            rvalid_q <= 1'b0;
        end else begin
            rd_en_q  <= rd_en;
            rvalid_q <= axil_rvalid & ~axil_rready;
        end
    end

    // Register file data is only valid in the cycle after rd_en
    always_ff @(posedge clk) begin
        if (rd_en_q) begin
            rdata_q <= rd_data;
        end
    end

    assign axil_rvalid = rd_en_q | rvalid_q;
    assign axil_rdata  = rd_en_q ? rd_data : rdata_q;
    assign axil_rresp  = axil_pkg::RESP_OKAY;

    a_rvalid_hold: assert property (@(posedge clk) disable iff (rst)
        axil_rvalid && !axil_rready |=> axil_rvalid && $stable(axil_rdata));

endmodule

// ==== csr/csr_file.sv ====
// UART control and status registers
`timescale 1ns/1ps

module csr_file (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        wr_en,
    input  axil_pkg::csr_wr_t           wr_req,
    input  logic                        rd_en,
    input  axil_pkg::csr_rd_t           rd_req,
    output logic [axil_pkg::DATA_W-1:0] rd_data,
    input  csr_pkg::uart_stat_t         hw_stat,
    output csr_pkg::uart_ctrl_t         hw_ctrl
);

    csr_pkg::uart_ctrl_t         ctrl_q;
    logic                        busy_q;
    logic                        rxe_q;
    logic                        txf_q;
    logic                        int_tx_q;
    logic                        int_rx_q;
    logic                        ctrl_we;
    logic                        lpmode_we;
    logic                        intstat_we;
    logic [axil_pkg::DATA_W-1:0] rd_mux;

    assign ctrl_we    = wr_en && (wr_req.addr == csr_pkg::ADDR_CTRL);
    assign lpmode_we  = wr_en && (wr_req.addr == csr_pkg::ADDR_LPMODE);
    assign intstat_we = wr_en && (wr_req.addr == csr_pkg::ADDR_INTSTAT);

    // --------------------------------------------------
    // CTRL and LPMODE
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            ctrl_q <= csr_pkg::CTRL_RESET;
        end else begin
            // Start pulse lasts one cycle
            ctrl_q.txst <= 1'b0;
            if (ctrl_we && wr_req.strb[0]) begin
                ctrl_q.baud <= wr_req.data[csr_pkg::CTRL_BAUD_LSB +: csr_pkg::CTRL_BAUD_W];
                ctrl_q.txen <= wr_req.data[csr_pkg::CTRL_TXEN_BIT];
                ctrl_q.rxen <= wr_req.data[csr_pkg::CTRL_RXEN_BIT];
                ctrl_q.txst <= wr_req.data[csr_pkg::CTRL_TXST_BIT];
            end else begin
                // Core loads its enables unless the bus writes them
                if (hw_stat.txen_en) begin
                    ctrl_q.txen <= hw_stat.txen;
                end
                if (hw_stat.rxen_en) begin
                    ctrl_q.rxen <= hw_stat.rxen;
                end
            end
            if (lpmode_we && wr_req.strb[0]) begin
                ctrl_q.div <= wr_req.data[csr_pkg::LPMODE_DIV_LSB +: csr_pkg::LPMODE_DIV_W];
            end
            if (lpmode_we && wr_req.strb[3]) begin
                ctrl_q.lp_en <= wr_req.data[csr_pkg::LPMODE_EN_BIT];
            end
        end
    end

    assign hw_ctrl = ctrl_q;

    // --------------------------------------------------
    // STAT and INTSTAT
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            busy_q   <= 1'b0;
            rxe_q    <= 1'b0;
            txf_q    <= 1'b0;
            int_tx_q <= 1'b0;
            int_rx_q <= 1'b0;
        end else begin
            rxe_q <= hw_stat.rxe;
            txf_q <= hw_stat.txf;
            if (hw_stat.busy_en) begin
                busy_q <= hw_stat.busy;
            end
            // Set wins over write-one-to-clear
            if (hw_stat.tx_set) begin
                int_tx_q <= 1'b1;
            end else if (intstat_we && wr_req.strb[0] && wr_req.data[csr_pkg::INT_TX_BIT]) begin
                int_tx_q <= 1'b0;
            end
            if (hw_stat.rx_set) begin
                int_rx_q <= 1'b1;
            end else if (intstat_we && wr_req.strb[0] && wr_req.data[csr_pkg::INT_RX_BIT]) begin
                int_rx_q <= 1'b0;
            end
        end
    end

    // --------------------------------------------------
    // Read mux
    // --------------------------------------------------
    always_comb begin
        rd_mux = '0;
        case (rd_req.addr)
            csr_pkg::ADDR_STAT: begin
                rd_mux[csr_pkg::STAT_BUSY_BIT] = busy_q;
                rd_mux[csr_pkg::STAT_RXE_BIT]  = rxe_q;
                rd_mux[csr_pkg::STAT_TXF_BIT]  = txf_q;
            end
            csr_pkg::ADDR_CTRL: begin
                rd_mux[csr_pkg::CTRL_BAUD_LSB +: csr_pkg::CTRL_BAUD_W] = ctrl_q.baud;
                rd_mux[csr_pkg::CTRL_TXEN_BIT] = ctrl_q.txen;
                rd_mux[csr_pkg::CTRL_RXEN_BIT] = ctrl_q.rxen;
            end
            csr_pkg::ADDR_LPMODE: begin
                rd_mux[csr_pkg::LPMODE_DIV_LSB +: csr_pkg::LPMODE_DIV_W] = ctrl_q.div;
                rd_mux[csr_pkg::LPMODE_EN_BIT] = ctrl_q.lp_en;
            end
            csr_pkg::ADDR_INTSTAT: begin
                rd_mux[csr_pkg::INT_TX_BIT] = int_tx_q;
                rd_mux[csr_pkg::INT_RX_BIT] = int_rx_q;
            end
            csr_pkg::ADDR_ID: rd_mux = csr_pkg::ID_VALUE;
            default: rd_mux = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_data <= '0;
        end else if (rd_en) begin
            rd_data <= rd_mux;
        end else begin
            rd_data <= '0;
        end
    end

    // A start pulse always traces back to a CTRL commit the cycle before
    a_txst_commit: assert property (@(posedge clk) disable iff (rst)
        ctrl_q.txst |-> $past(ctrl_we && wr_req.strb[0]));

endmodule

// ==== src/uart_csr_top.sv ====
// UART register block top level
`timescale 1ns/1ps

module uart_csr_top (
    input  logic                        clk,
    input  logic                        rst,
    // AXI4-Lite write
    input  logic [axil_pkg::ADDR_W-1:0] axil_awaddr,
    input  logic                        axil_awvalid,
    output logic                        axil_awready,
    input  logic [axil_pkg::DATA_W-1:0] axil_wdata,
    input  logic [axil_pkg::STRB_W-1:0] axil_wstrb,
    input  logic                        axil_wvalid,
    output logic                        axil_wready,
    output logic [axil_pkg::RESP_W-1:0] axil_bresp,
    output logic                        axil_bvalid,
    input  logic                        axil_bready,
    // AXI4-Lite read
    input  logic [axil_pkg::ADDR_W-1:0] axil_araddr,
    input  logic                        axil_arvalid,
    output logic                        axil_arready,
    output logic [axil_pkg::DATA_W-1:0] axil_rdata,
    output logic [axil_pkg::RESP_W-1:0] axil_rresp,
    output logic                        axil_rvalid,
    input  logic                        axil_rready,
    // UART core side
    input  csr_pkg::uart_stat_t         hw_stat,
    output csr_pkg::uart_ctrl_t         hw_ctrl
);

    logic                        wr_en;
    axil_pkg::csr_wr_t           wr_req;
    logic                        rd_en;
    axil_pkg::csr_rd_t           rd_req;
    logic [axil_pkg::DATA_W-1:0] rd_data;

    axil_write_ctrl u_write_ctrl (
        .clk          (clk),
        .rst          (rst),
        .axil_awaddr  (axil_awaddr),
        .axil_awvalid (axil_awvalid),
        .axil_awready (axil_awready),
        .axil_wdata   (axil_wdata),
        .axil_wstrb   (axil_wstrb),
        .axil_wvalid  (axil_wvalid),
        .axil_wready  (axil_wready),
        .axil_bresp   (axil_bresp),
        .axil_bvalid  (axil_bvalid),
        .axil_bready  (axil_bready),
        .wr_en        (wr_en),
        .wr_req       (wr_req)
    );

    axil_read_ctrl u_read_ctrl (
        .clk          (clk),
        .rst          (rst),
        .axil_araddr  (axil_araddr),
        .axil_arvalid (axil_arvalid),
        .axil_arready (axil_arready),
        .axil_rdata   (axil_rdata),
        .axil_rresp   (axil_rresp),
        .axil_rvalid  (axil_rvalid),
        .axil_rready  (axil_rready),
        .rd_en        (rd_en),
        .rd_req       (rd_req),
        .rd_data      (rd_data)
    );

    csr_file u_csr_file (
        .clk     (clk),
        .rst     (rst),
        .wr_en   (wr_en),
        .wr_req  (wr_req),
        .rd_en   (rd_en),
        .rd_req  (rd_req),
        .rd_data (rd_data),
        .hw_stat (hw_stat),
        .hw_ctrl (hw_ctrl)
    );

endmodule

// ==== test/tb_axil_tasks.svh ====
// AXI4-Lite driver tasks
`ifndef TB_AXIL_TASKS_SVH
`define TB_AXIL_TASKS_SVH

// Fibonacci LFSR with taps 32 22 2 1
// One step per bit returned
function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    logic        fb;
    v = '0;
    for (int i = 0; i < n; i++) begin
        fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
        lfsr_q = {lfsr_q[30:0], fb};
        v      = {v[30:0], fb};
    end
    return v;
endfunction

// All tasks start and end on a falling edge
task automatic send_aw(input logic [15:0] addr, input int delay);
    logic hs;
    repeat (delay) @(negedge clk);
    axil_awaddr  = addr;
    axil_awvalid = 1'b1;
    hs = 1'b0;
    while (!hs) begin
        hs = axil_awready;
        @(negedge clk);
    end
    axil_awvalid = 1'b0;
endtask

task automatic send_w(input logic [31:0] data, input logic [3:0] strb, input int delay);
    logic hs;
    repeat (delay) @(negedge clk);
    axil_wdata  = data;
    axil_wstrb  = strb;
    axil_wvalid = 1'b1;
    hs = 1'b0;
    while (!hs) begin
        hs = axil_wready;
        @(negedge clk);
    end
    axil_wvalid = 1'b0;
endtask

task automatic send_ar(input logic [15:0] addr);
    logic hs;
    axil_araddr  = addr;
    axil_arvalid = 1'b1;
    hs = 1'b0;
    while (!hs) begin
        hs = axil_arready;
        @(negedge clk);
    end
    axil_arvalid = 1'b0;
endtask

task automatic take_b(input int b_delay);
    while (!axil_bvalid) @(negedge clk);
    // First cycle after the commit edge
    txst_at_b = hw_ctrl.txst;
    repeat (b_delay) @(negedge clk);
    expect_value("axil_bresp", 32'h0, {30'b0, axil_bresp});
    axil_bready = 1'b1;
    @(negedge clk);
    axil_bready = 1'b0;
endtask

// Order 0 sends AW first, 1 sends W first, 2 sends both together
task automatic axil_write(input logic [15:0] addr, input logic [31:0] data,
                          input logic [3:0] strb, input int order, input int gap,
                          input int b_delay);
    int aw_delay;
    int w_delay;
    aw_delay = (order == 1) ? gap : 0;
    w_delay  = (order == 0) ? gap : 0;
    fork
        send_aw(addr, aw_delay);
        send_w(data, strb, w_delay);
    join
    take_b(b_delay);
    model_write(addr, data, strb);
    writes_issued++;
endtask

task automatic axil_read(input logic [15:0] addr, input int r_delay,
                         output logic [31:0] data);
    logic [31:0] first;
    send_ar(addr);
    while (!axil_rvalid) @(negedge clk);
    first = axil_rdata;
    repeat (r_delay) @(negedge clk);
    expect_value("axil_rdata hold", first, axil_rdata);
    expect_value("axil_rresp", 32'h0, {30'b0, axil_rresp});
    data = axil_rdata;
    axil_rready = 1'b1;
    @(negedge clk);
    axil_rready = 1'b0;
endtask

`endif

// ==== test/tb_uart_csr.sv ====
// UART register block testbench
`timescale 1ns/1ps

module tb_uart_csr;

    localparam int MAX_TXNS       = 200;
    localparam int TXN_CYCLES     = 20;
    localparam int TIMEOUT_CYCLES = MAX_TXNS * TXN_CYCLES + 1000;

    logic                clk;
    logic                rst;
    logic [15:0]         axil_awaddr;
    logic                axil_awvalid;
    logic                axil_awready;
    logic [31:0]         axil_wdata;
    logic [3:0]          axil_wstrb;
    logic                axil_wvalid;
    logic                axil_wready;
    logic [1:0]          axil_bresp;
    logic                axil_bvalid;
    logic                axil_bready;
    logic [15:0]         axil_araddr;
    logic                axil_arvalid;
    logic                axil_arready;
    logic [31:0]         axil_rdata;
    logic [1:0]          axil_rresp;
    logic                axil_rvalid;
    logic                axil_rready;
    csr_pkg::uart_stat_t hw_stat;
    csr_pkg::uart_ctrl_t hw_ctrl;

    logic [31:0] lfsr_q = 32'ha62b_55a5;
    logic        txst_at_b;
    int          txst_cycles;
    int          commits;
    int          writes_issued;
    int          pass_count;
    int          fail_count;
    int          test_fail_base;
    int          cycle_count;
    logic [15:0] addr_list [8];

    // Register model
    logic [1:0] m_baud;
    logic       m_txen;
    logic       m_rxen;
    logic [7:0] m_div;
    logic       m_lpen;
    logic       m_busy;
    logic       m_rxe;
    logic       m_txf;
    logic       m_int_tx;
    logic       m_int_rx;

    // Checks queued for the compare process
    string       name_q [$];
    logic [31:0] exp_q [$];
    logic [31:0] got_q [$];

    uart_csr_top u_dut (.*);

    task automatic expect_value(input string name, input logic [31:0] exp,
                                input logic [31:0] got);
        name_q.push_back(name);
        exp_q.push_back(exp);
        got_q.push_back(got);
    endtask

    task automatic model_write(input logic [15:0] addr, input logic [31:0] data,
                               input logic [3:0] strb);
        if (addr == 16'h0008 && strb[0]) begin
            m_baud = data[1:0];
            m_txen = data[4];
            m_rxen = data[5];
        end
        if (addr == 16'h000C && strb[0]) m_div = data[7:0];
        if (addr == 16'h000C && strb[3]) m_lpen = data[31];
        if (addr == 16'h0010 && strb[0]) begin
            if (data[0]) m_int_tx = 1'b0;
            if (data[1]) m_int_rx = 1'b0;
        end
    endtask

    // Expected read value from the model
    function automatic logic [31:0] expected_read(input logic [15:0] addr);
        logic [31:0] v;
        v = '0;
        case (addr)
            16'h0004: begin
                v[0] = m_busy;
                v[4] = m_rxe;
                v[5] = m_txf;
            end
            16'h0008: v = {26'b0, m_rxen, m_txen, 2'b0, m_baud};
            16'h000C: v = {m_lpen, 23'b0, m_div};
            16'h0010: v = {30'b0, m_int_rx, m_int_tx};
            16'h0FFC: v = 32'hCAFE0666;
            default:  v = '0;
        endcase
        return v;
    endfunction

    function automatic logic [31:0] expected_ctrl();
        return {18'b0, m_baud, m_txen, m_rxen, 1'b0, m_div, m_lpen};
    endfunction

    `include "tb_axil_tasks.svh"

    task automatic check_read(input logic [15:0] addr, input int r_delay);
        logic [31:0] data;
        axil_read(addr, r_delay, data);
        expect_value($sformatf("axil_rdata@%h", addr), expected_read(addr), data);
    endtask

    task automatic check_hw_ctrl();
        expect_value("hw_ctrl", expected_ctrl(), {18'b0, hw_ctrl});
    endtask

    task automatic end_test(input string name);
        repeat (2) @(negedge clk);
        $display("Test %s finished with %0d errors", name, fail_count - test_fail_base);
        test_fail_base = fail_count;
    endtask

    // --------------------------------------------------
    // Clock, timeout, monitors and checker
    // --------------------------------------------------
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("*** FAILED ***");
        $finish;
    end

    always @(negedge clk) begin
        if (hw_ctrl.txst) txst_cycles++;
        if (u_dut.u_write_ctrl.wr_en) commits++;
    end

    initial begin : compare
        string       name;
        logic [31:0] exp;
        logic [31:0] got;
        forever begin
            @(negedge clk);
            while (name_q.size() > 0) begin
                name = name_q.pop_front();
                exp  = exp_q.pop_front();
                got  = got_q.pop_front();
                assert (got === exp) pass_count++;
                else begin
                    $display("Fail at %0t: %s expected %h got %h", $time, name, exp, got);
                    fail_count++;
                end
            end
        end
    end

    // --------------------------------------------------
    // Test sequence
    // --------------------------------------------------
    initial begin : main
        logic [31:0] r;
        logic [31:0] data;
        logic [3:0]  strb;
        logic [15:0] addr;
        int          base;
        rst = 1'b1;
        {axil_awvalid, axil_wvalid, axil_bready, axil_arvalid, axil_rready} = '0;
        axil_awaddr = '0;
        axil_wdata  = '0;
        axil_wstrb  = '0;
        axil_araddr = '0;
        hw_stat     = '0;
        {m_baud, m_txen, m_rxen, m_div, m_lpen} = '0;
        {m_busy, m_rxe, m_txf, m_int_tx, m_int_rx} = '0;
        {txst_cycles, commits, writes_issued, pass_count, fail_count, test_fail_base} = '0;
        addr_list = '{16'h0004, 16'h0008, 16'h000C, 16'h0010,
                      16'h0FFC, 16'h0000, 16'h0014, 16'h0800};
        repeat (8) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);

        for (int i = 0; i < 8; i++) check_read(addr_list[i], 0);
        check_hw_ctrl();
        end_test("reset_values");

        for (int i = 0; i < 16; i++) begin
            r    = rand_bits(1);
            addr = r[0] ? 16'h000C : 16'h0008;
            data = rand_bits(32);
            r    = rand_bits(4);
            strb = r[3:0];
            axil_write(addr, data, strb, 2, 0, 0);
            check_read(addr, 0);
            check_hw_ctrl();
        end
        end_test("strobed_readback");

        txst_cycles = 0;
        axil_write(16'h0008, 32'h0000_0071, 4'h1, 2, 0, 1);
        repeat (4) @(negedge clk);
        expect_value("hw_ctrl.txst at commit", 32'd1, {31'b0, txst_at_b});
        expect_value("txst high cycles", 32'd1, txst_cycles);
        check_read(16'h0008, 0);
        end_test("txst_pulse");

        hw_stat.rxe  = 1'b1;
        hw_stat.busy = 1'b1;
        m_rxe = 1'b1;
        @(negedge clk);
        check_read(16'h0004, 0);
        hw_stat.busy_en = 1'b1;
        hw_stat.txf     = 1'b1;
        hw_stat.rxe     = 1'b0;
        {m_busy, m_txf, m_rxe} = 3'b110;
        @(negedge clk);
        hw_stat.busy_en = 1'b0;
        hw_stat.busy    = 1'b0;
        check_read(16'h0004, 1);
        axil_write(16'h0008, 32'h0000_0030, 4'h1, 2, 0, 0);
        hw_stat.txen_en = 1'b1;
        m_txen = 1'b0;
        @(negedge clk);
        hw_stat.txen_en = 1'b0;
        check_read(16'h0008, 0);
        check_hw_ctrl();
        hw_stat.rxen_en = 1'b1;
        m_rxen = 1'b0;
        @(negedge clk);
        hw_stat.rxen_en = 1'b0;
        check_read(16'h0008, 0);
        check_hw_ctrl();
        end_test("status_override");

        hw_stat.tx_set = 1'b1;
        hw_stat.rx_set = 1'b1;
        {m_int_tx, m_int_rx} = 2'b11;
        @(negedge clk);
        {hw_stat.tx_set, hw_stat.rx_set} = 2'b00;
        check_read(16'h0010, 0);
        axil_write(16'h0010, 32'h2, 4'h1, 2, 0, 0);
        check_read(16'h0010, 0);
        // Clear TX while the core sets it in the commit cycle
        axil_awaddr  = 16'h0010;
        axil_wdata   = 32'h1;
        axil_wstrb   = 4'h1;
        axil_awvalid = 1'b1;
        axil_wvalid  = 1'b1;
        @(negedge clk);
        axil_awvalid   = 1'b0;
        axil_wvalid    = 1'b0;
        hw_stat.tx_set = 1'b1;
        @(negedge clk);
        hw_stat.tx_set = 1'b0;
        take_b(0);
        check_read(16'h0010, 0);
        axil_write(16'h0010, 32'h1, 4'h1, 2, 0, 0);
        check_read(16'h0010, 0);
        end_test("interrupt_flags");

        base = commits - writes_issued;
        for (int i = 0; i < 40; i++) begin
            r    = rand_bits(3);
            addr = addr_list[r[2:0]];
            data = rand_bits(32);
            r    = rand_bits(4);
            strb = r[3:0];
            axil_write(addr, data, strb, int'(rand_bits(2)) % 3, int'(rand_bits(2)),
                       int'(rand_bits(2)));
            r = rand_bits(3);
            check_read(addr_list[r[2:0]], int'(rand_bits(2)));
        end
        repeat (2) @(negedge clk);
        expect_value("commit count", writes_issued, commits - base);
        check_hw_ctrl();
        end_test("ordering_backpressure");

        $display("Checks passed %0d, failed %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// ==== vlog.f ====
+incdir+test
common/axil_pkg.sv
common/csr_pkg.sv
axil/axil_hold.sv
axil/axil_write_ctrl.sv
axil/axil_read_ctrl.sv
csr/csr_file.sv
src/uart_csr_top.sv
test/tb_uart_csr.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the UART register block testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f vlog.f --top-module tb_uart_csr \
    -o sim_tb_uart_csr > build.log 2>&1
if [ $? -ne 0 ]; then
    echo "Verilator build failed, see build.log"
    exit 1
fi

./obj_dir/sim_tb_uart_csr > sim.log 2>&1
if [ $? -ne 0 ]; then
    echo "Simulation exited with an error, see sim.log"
    exit 1
fi

if grep -q '^\*\*\* PASSED \*\*\*$' sim.log; then
    echo "Simulation passed"
    exit 0
fi

echo "Simulation failed, see sim.log"
exit 1
